//--- rtl/word_gen_pkg.sv
`default_nettype none

package word_gen_pkg;

	// ******************************
	// sizes
	// ******************************

	// bits per character
	localparam int CHAR_BITS = 8;
	// characters per template or candidate word
	localparam int WORD_MAX_LEN = 8;
	// width of a position index inside a word
	localparam int POS_BITS = 3;

	// closing byte of a configuration
	localparam logic [CHAR_BITS-1:0] CONF_MAGIC = 8'hBB;

	// ******************************
	// basic types
	// ******************************

	typedef logic [CHAR_BITS-1:0] char_t;

	// character 0 sits in the low byte
	typedef char_t [WORD_MAX_LEN-1:0] word_t;

	typedef logic [POS_BITS-1:0] pos_t;

	// ******************************
	// stream payloads
	// ******************************

	// template word from the word list
	typedef struct packed {
		word_t       text;
		logic [15:0] word_id;
		// dummy word that closes the list
		logic        list_end;
	} word_in_t;

	// one generated candidate
	typedef struct packed {
		word_t       text;
		logic [15:0] word_id;
		// running number within the template word
		logic [31:0] gen_id;
		// last combination of this word
		logic        word_end;
		// dummy candidate after the last word of the list
		logic        gen_end;
	} cand_t;

endpackage

`default_nettype wire

//--- rtl/word_gen_char_range.sv
`default_nettype none

module word_gen_char_range #(
	parameter int CHARS_MAX = 16
) (
	input  logic WORD_GEN_CLK,
	input  logic rst_n,
	// table load
	input  logic wr,
	input  logic [((CHARS_MAX > 1) ? $clog2(CHARS_MAX) : 1)-1:0] addr,
	input  word_gen_pkg::char_t wr_char,
	input  logic last_wr,
	input  logic [((CHARS_MAX > 1) ? $clog2(CHARS_MAX) : 1)-1:0] last,
	// digit control
	input  logic rewind,
	input  logic step,
	input  logic carry_in,
	output word_gen_pkg::char_t char_out,
	output logic carry_out
);

	localparam int ADDR_BITS = (CHARS_MAX > 1) ? $clog2(CHARS_MAX) : 1;

	word_gen_pkg::char_t char_tbl [CHARS_MAX];
	logic [ADDR_BITS-1:0] last_idx;
	// current digit of this range
	logic [ADDR_BITS-1:0] cnt;
	logic at_last;

	always_ff @(posedge WORD_GEN_CLK) begin
		if (wr) begin
			char_tbl[addr] <= wr_char;
		end
	end

	always_ff @(posedge WORD_GEN_CLK) begin
		if (!rst_n) begin
			last_idx <= '0;
			cnt <= '0;
		end else begin
			if (last_wr) begin
				last_idx <= last;
			end
			// digit wraps at the last char and carries upward
			if (rewind) begin
				cnt <= '0;
			end else if (step && carry_in) begin
				cnt <= at_last ? '0 : cnt + 1'b1;
			end
		end
	end

	assign at_last = cnt == last_idx;
	assign carry_out = carry_in & at_last;
	assign char_out = char_tbl[cnt];

endmodule

`default_nettype wire

//--- rtl/range_insert.sv
`default_nettype none

module range_insert #(
	parameter int RANGES_MAX = 3
) (
	input  word_gen_pkg::word_t text,
	input  word_gen_pkg::char_t [RANGES_MAX-1:0] chars,
	input  word_gen_pkg::pos_t [RANGES_MAX-1:0] pos,
	input  logic [RANGES_MAX-1:0] active,
	output word_gen_pkg::word_t merged
);

	// ******************************
	// character placement
	// ******************************

	always_comb begin
		merged = text;
		// later ranges overwrite earlier ones on a shared position
		for (int r = 0; r < RANGES_MAX; r++) begin
			if (active[r]) begin
				merged[pos[r]] = chars[r];
			end
		end
	end

endmodule

`default_nettype wire

//--- rtl/word_gen_conf.sv
`default_nettype none

module word_gen_conf #(
	parameter int RANGES_MAX = 3,
	parameter int CHARS_MAX = 16
) (
	input  logic WORD_GEN_CLK,
	input  logic rst_n,
	// configuration byte stream
	input  word_gen_pkg::char_t conf_data,
	input  logic conf_valid,
	output logic conf_ready,
	// range table write port towards the core
	output logic tbl_wr,
	output logic [((RANGES_MAX > 1) ? $clog2(RANGES_MAX) : 1)-1:0] tbl_range,
	output logic [((CHARS_MAX > 1) ? $clog2(CHARS_MAX) : 1)-1:0] tbl_addr,
	output word_gen_pkg::char_t tbl_char,
	output logic tbl_last_wr,
	output logic [((CHARS_MAX > 1) ? $clog2(CHARS_MAX) : 1)-1:0] tbl_last,
	output logic [$clog2(RANGES_MAX+1)-1:0] num_ranges,
	output logic conf_done,
	output logic err_conf,
	// end of the word list seen by the core
	input  logic list_done
);

	localparam int RANGE_BITS = (RANGES_MAX > 1) ? $clog2(RANGES_MAX) : 1;
	localparam int ADDR_BITS = (CHARS_MAX > 1) ? $clog2(CHARS_MAX) : 1;
	localparam int NR_BITS = $clog2(RANGES_MAX+1);

	typedef enum logic [2:0] {
		ST_NUM_RANGES,
		ST_NUM_CHARS,
		ST_CHARS,
		ST_MAGIC,
		ST_DONE,
		ST_ERROR
	} conf_state_t;

	conf_state_t state;
	logic [RANGE_BITS-1:0] range_cnt;
	logic [ADDR_BITS-1:0] char_cnt;
	// index of the last char of the range being loaded
	logic [ADDR_BITS-1:0] last_r;
	logic acc;
	logic num_chars_ok;

	// no bytes taken while generating or after an error
	assign conf_ready = (state != ST_DONE) && (state != ST_ERROR);
	assign acc = conf_valid & conf_ready;
	assign conf_done = state == ST_DONE;
	assign err_conf = state == ST_ERROR;

	assign num_chars_ok = (conf_data != 8'd0) && (conf_data <= CHARS_MAX);

	// each accepted char or count byte turns into a table write
	assign tbl_wr = acc && (state == ST_CHARS);
	assign tbl_range = range_cnt;
	assign tbl_addr = char_cnt;
	assign tbl_char = conf_data;
	assign tbl_last_wr = acc && (state == ST_NUM_CHARS) && num_chars_ok;
	assign tbl_last = ADDR_BITS'(conf_data - 8'd1);

	always_ff @(posedge WORD_GEN_CLK) begin
		if (!rst_n) begin
			state <= ST_NUM_RANGES;
			range_cnt <= '0;
			char_cnt <= '0;
			last_r <= '0;
			num_ranges <= '0;
		end else begin
			case (state)
				ST_NUM_RANGES: if (acc) begin
					range_cnt <= '0;
					if (conf_data > RANGES_MAX) begin
						state <= ST_ERROR;
					end else begin
						num_ranges <= conf_data[NR_BITS-1:0];
						// zero ranges means templates pass through
						state <= (conf_data == 8'd0) ? ST_MAGIC : ST_NUM_CHARS;
					end
				end
				ST_NUM_CHARS: if (acc) begin
					char_cnt <= '0;
					last_r <= tbl_last;
					state <= num_chars_ok ? ST_CHARS : ST_ERROR;
				end
				ST_CHARS: if (acc) begin
					char_cnt <= char_cnt + 1'b1;
					if (char_cnt == last_r) begin
						// range complete, move on or close with magic
						if (NR_BITS'(range_cnt) + 1'b1 == num_ranges) begin
							state <= ST_MAGIC;
						end else begin
							range_cnt <= range_cnt + 1'b1;
							state <= ST_NUM_CHARS;
						end
					end
				end
				ST_MAGIC: if (acc) begin
					state <= (conf_data == word_gen_pkg::CONF_MAGIC) ? ST_DONE : ST_ERROR;
				end
				// back to a fresh configuration once the list is done
				ST_DONE: if (list_done) begin
					state <= ST_NUM_RANGES;
				end
				// error holds until reset
				default: state <= ST_ERROR;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- rtl/word_gen_core.sv
`default_nettype none

module word_gen_core #(
	parameter int RANGES_MAX = 3,
	parameter int CHARS_MAX = 16
) (
	input  logic WORD_GEN_CLK,
	input  logic rst_n,
	// range table write port from the configuration block
	input  logic tbl_wr,
	input  logic [((RANGES_MAX > 1) ? $clog2(RANGES_MAX) : 1)-1:0] tbl_range,
	input  logic [((CHARS_MAX > 1) ? $clog2(CHARS_MAX) : 1)-1:0] tbl_addr,
	input  word_gen_pkg::char_t tbl_char,
	input  logic tbl_last_wr,
	input  logic [((CHARS_MAX > 1) ? $clog2(CHARS_MAX) : 1)-1:0] tbl_last,
	input  logic [$clog2(RANGES_MAX+1)-1:0] num_ranges,
	input  logic conf_done,
	output logic list_done,
	// template stream
	input  word_gen_pkg::word_in_t word_in,
	input  logic word_valid,
	output logic word_ready,
	input  word_gen_pkg::pos_t [RANGES_MAX-1:0] range_pos,
	// candidate stream
	output word_gen_pkg::cand_t cand,
	output logic cand_valid,
	input  logic cand_ready
);

	localparam int RANGE_BITS = (RANGES_MAX > 1) ? $clog2(RANGES_MAX) : 1;
	localparam int NR_BITS = $clog2(RANGES_MAX+1);

	word_gen_pkg::word_in_t tmpl;
	logic word_held;
	logic [31:0] gen_id;
	logic accept;
	logic fire;
	logic last_cand;
	word_gen_pkg::char_t [RANGES_MAX-1:0] range_char;
	logic [RANGES_MAX-1:0] active;
	logic [RANGES_MAX-1:0] range_carry;
	logic [RANGES_MAX-1:0] carry_in;
	logic [RANGES_MAX-1:0] carry_pass;
	word_gen_pkg::word_t merged;

	assign word_ready = conf_done & ~word_held;
	assign accept = word_valid & word_ready;
	assign cand_valid = word_held;
	assign fire = cand_valid & cand_ready;

	// ******************************
	// ranges and carry chain
	// ******************************

	for (genvar r = 0; r < RANGES_MAX; r++) begin : g_range
		assign active[r] = NR_BITS'(r) < num_ranges;
		// last range counts fastest, carry moves toward range 0
		assign carry_in[r] = (r == RANGES_MAX-1) ? 1'b1 : carry_pass[(r+1) % RANGES_MAX];
		// unused ranges are transparent to the carry
		assign carry_pass[r] = active[r] ? range_carry[r] : carry_in[r];

		word_gen_char_range #(
			.CHARS_MAX(CHARS_MAX)
		) u_range (
			.WORD_GEN_CLK(WORD_GEN_CLK),
			.rst_n(rst_n),
			.wr(tbl_wr && (tbl_range == RANGE_BITS'(r))),
			.addr(tbl_addr),
			.wr_char(tbl_char),
			.last_wr(tbl_last_wr && (tbl_range == RANGE_BITS'(r))),
			.last(tbl_last),
			.rewind(accept),
			.step(fire & ~tmpl.list_end),
			.carry_in(carry_in[r]),
			.char_out(range_char[r]),
			.carry_out(range_carry[r])
		);
	end

	range_insert #(
		.RANGES_MAX(RANGES_MAX)
	) u_insert (
		.text(tmpl.text),
		.chars(range_char),
		.pos(range_pos),
		.active(tmpl.list_end ? '0 : active),
		.merged(merged)
	);

	// ******************************
	// word intake and output
	// ******************************

	// all digits at their last char, or the list-end dummy
	assign last_cand = carry_pass[0] | tmpl.list_end;
	assign list_done = fire & tmpl.list_end;

	always_ff @(posedge WORD_GEN_CLK) begin
		if (accept) begin
			tmpl <= word_in;
		end
	end

	always_ff @(posedge WORD_GEN_CLK) begin
		if (!rst_n) begin
			word_held <= 1'b0;
			gen_id <= '0;
		end else if (accept) begin
			word_held <= 1'b1;
			gen_id <= '0;
		end else if (fire) begin
			word_held <= ~last_cand;
			gen_id <= last_cand ? '0 : gen_id + 1'b1;
		end
	end

	assign cand.text = merged;
	assign cand.word_id = tmpl.word_id;
	assign cand.gen_id = gen_id;
	assign cand.word_end = last_cand;
	assign cand.gen_end = tmpl.list_end;

endmodule

`default_nettype wire

//--- rtl/word_gen.sv
`default_nettype none

module word_gen #(
	parameter int RANGES_MAX = 3,
	// power of two, 256 at most
	parameter int CHARS_MAX = 16
) (
	input  logic WORD_GEN_CLK,
	input  logic rst_n,
	// configuration bytes
	input  word_gen_pkg::char_t conf_data,
	input  logic conf_valid,
	output logic conf_ready,
	// template words
	input  word_gen_pkg::word_in_t word_in,
	input  logic word_valid,
	output logic word_ready,
	// insert position of each range
	input  word_gen_pkg::pos_t [RANGES_MAX-1:0] range_pos,
	// candidates
	output word_gen_pkg::cand_t cand,
	output logic cand_valid,
	input  logic cand_ready,
	output logic err_conf
);

	localparam int RANGE_BITS = (RANGES_MAX > 1) ? $clog2(RANGES_MAX) : 1;
	localparam int ADDR_BITS = (CHARS_MAX > 1) ? $clog2(CHARS_MAX) : 1;
	localparam int NR_BITS = $clog2(RANGES_MAX+1);

	logic tbl_wr;
	logic [RANGE_BITS-1:0] tbl_range;
	logic [ADDR_BITS-1:0] tbl_addr;
	word_gen_pkg::char_t tbl_char;
	logic tbl_last_wr;
	logic [ADDR_BITS-1:0] tbl_last;
	logic [NR_BITS-1:0] num_ranges;
	logic conf_done;
	logic list_done;

	word_gen_conf #(
		.RANGES_MAX(RANGES_MAX),
		.CHARS_MAX(CHARS_MAX)
	) u_conf (
		.WORD_GEN_CLK(WORD_GEN_CLK), .rst_n(rst_n),
		.conf_data(conf_data), .conf_valid(conf_valid), .conf_ready(conf_ready),
		.tbl_wr(tbl_wr), .tbl_range(tbl_range), .tbl_addr(tbl_addr),
		.tbl_char(tbl_char), .tbl_last_wr(tbl_last_wr), .tbl_last(tbl_last),
		.num_ranges(num_ranges), .conf_done(conf_done), .err_conf(err_conf),
		.list_done(list_done)
	);

	word_gen_core #(
		.RANGES_MAX(RANGES_MAX),
		.CHARS_MAX(CHARS_MAX)
	) u_core (
		.WORD_GEN_CLK(WORD_GEN_CLK), .rst_n(rst_n),
		.tbl_wr(tbl_wr), .tbl_range(tbl_range), .tbl_addr(tbl_addr),
		.tbl_char(tbl_char), .tbl_last_wr(tbl_last_wr), .tbl_last(tbl_last),
		.num_ranges(num_ranges), .conf_done(conf_done), .list_done(list_done),
		.word_in(word_in), .word_valid(word_valid), .word_ready(word_ready),
		.range_pos(range_pos),
		.cand(cand), .cand_valid(cand_valid), .cand_ready(cand_ready)
	);

endmodule

`default_nettype wire

//--- dv/word_gen_checker.sv
`default_nettype none

module word_gen_checker #(
	parameter int RANGES_MAX = 3,
	parameter int CHARS_MAX = 16
) (
	input  logic WORD_GEN_CLK,
	input  logic rst_n,
	input  word_gen_pkg::cand_t cand,
	input  logic cand_valid,
	input  logic cand_ready,
	input  logic conf_ready,
	input  logic word_ready,
	input  logic err_conf,
	input  word_gen_pkg::pos_t [RANGES_MAX-1:0] range_pos
);

	// configuration and templates as last sent by the testbench
	int conf_nr = 0;
	int conf_cnt [RANGES_MAX];
	word_gen_pkg::char_t conf_chr [RANGES_MAX][CHARS_MAX];
	word_gen_pkg::word_in_t tmpl_q [$];
	// position in the expected candidate stream
	int tidx = 0;
	int gen_idx = 0;
	// per test and overall bookkeeping
	int seen = 0;
	int errs = 0;
	int pass_cnt = 0;
	int fail_cnt = 0;
	logic ready_check = 1'b0;
	word_gen_pkg::cand_t exp_c;

	// ******************************
	// expected candidate
	// ******************************

	function automatic word_gen_pkg::cand_t expect_cand(
		input word_gen_pkg::word_in_t w,
		input int n
	);
		word_gen_pkg::cand_t c;
		int digit [RANGES_MAX];
		int rest;
		int total;
		rest = n;
		total = 1;
		// mixed radix count, the last range is the low digit
		for (int r = RANGES_MAX - 1; r >= 0; r--) begin
			digit[r] = 0;
			if (r < conf_nr) begin
				digit[r] = rest % conf_cnt[r];
				rest = rest / conf_cnt[r];
				total = total * conf_cnt[r];
			end
		end
		c.text = w.text;
		c.word_id = w.word_id;
		c.gen_id = n;
		// list end dummy is always a single candidate
		c.word_end = w.list_end || (n == total - 1);
		c.gen_end = w.list_end;
		if (!w.list_end) begin
			// ascending order, a higher range wins a shared position
			for (int r = 0; r < conf_nr; r++) begin
				c.text[range_pos[r]] = conf_chr[r][digit[r]];
			end
		end
		return c;
	endfunction

	// ******************************
	// setup from the testbench
	// ******************************

	task automatic set_ranges(input int n);
		conf_nr = n;
	endtask

	task automatic set_range(input int r, input int n);
		conf_cnt[r] = n;
	endtask

	task automatic set_char(input int r, input int i, input word_gen_pkg::char_t c);
		conf_chr[r][i] = c;
	endtask

	task automatic add_template(input word_gen_pkg::word_in_t w);
		tmpl_q.push_back(w);
	endtask

	task automatic start_test();
		tmpl_q.delete();
		tidx = 0;
		gen_idx = 0;
		seen = 0;
		errs = 0;
	endtask

	function automatic bit all_seen();
		return tidx == tmpl_q.size();
	endfunction

	// ******************************
	// comparison and reporting
	// ******************************

	task automatic check_value(input string name, input logic [63:0] want,
		input logic [63:0] got);
		if (want !== got) begin
			$display("mismatch %s: expected %0h, got %0h", name, want, got);
			errs++;
		end
	endtask

	// parser stuck in its error state
	task automatic check_err_state();
		check_value("err_conf", 64'd1, {63'd0, err_conf});
		check_value("conf_ready", 64'd0, {63'd0, conf_ready});
		check_value("word_ready", 64'd0, {63'd0, word_ready});
	endtask

	task automatic end_test(input string name);
		if (errs == 0) begin
			pass_cnt++;
		end else begin
			fail_cnt++;
		end
		$display("test %s: %s, %0d candidates, %0d errors", name,
			(errs == 0) ? "ok" : "FAIL", seen, errs);
	endtask

	task automatic report_totals();
		$display("tests ok: %0d, tests failing: %0d", pass_cnt, fail_cnt);
	endtask

	always @(posedge WORD_GEN_CLK) begin
		if (rst_n) begin
			// list end hands control back to the config parser
			if (ready_check) begin
				ready_check = 1'b0;
				check_value("conf_ready", 64'd1, {63'd0, conf_ready});
			end
			if (cand_valid && cand_ready) begin
				seen++;
				// parser and word intake stay closed while a candidate is out
				check_value("conf_ready", 64'd0, {63'd0, conf_ready});
				check_value("word_ready", 64'd0, {63'd0, word_ready});
				check_value("err_conf", 64'd0, {63'd0, err_conf});
				if (tidx >= tmpl_q.size()) begin
					$display("unexpected candidate with word_id %0h after the last template",
						cand.word_id);
					errs++;
				end else begin
					exp_c = expect_cand(tmpl_q[tidx], gen_idx);
					check_value("cand.text", exp_c.text, cand.text);
					check_value("cand.word_id", 64'(exp_c.word_id), 64'(cand.word_id));
					check_value("cand.gen_id", 64'(exp_c.gen_id), 64'(cand.gen_id));
					check_value("cand.word_end", 64'(exp_c.word_end), 64'(cand.word_end));
					check_value("cand.gen_end", 64'(exp_c.gen_end), 64'(cand.gen_end));
					ready_check = exp_c.gen_end;
					// next template after the last combination
					if (exp_c.word_end) begin
						tidx++;
						gen_idx = 0;
					end else begin
						gen_idx++;
					end
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- dv/word_gen_tb.sv
`default_nettype none

module word_gen_tb;

	localparam int RANGES_MAX = 3;
	localparam int CHARS_MAX = 16;
	// config bytes and candidates summed over the tests below
	localparam int BYTES_TOTAL = 43;
	localparam int CANDS_TOTAL = 85;
	localparam int WATCHDOG_CYCLES = (BYTES_TOTAL + CANDS_TOTAL) * 4 + 200;

	logic WORD_GEN_CLK;
	logic rst_n;
	word_gen_pkg::char_t conf_data;
	logic conf_valid;
	logic conf_ready;
	word_gen_pkg::word_in_t word_in;
	logic word_valid;
	logic word_ready;
	word_gen_pkg::pos_t [RANGES_MAX-1:0] range_pos;
	word_gen_pkg::cand_t cand;
	logic cand_valid;
	logic cand_ready;
	logic err_conf;

	logic [31:0] lfsr = 32'hf7dd_619f;
	logic stall_on;
	logic [15:0] next_id;
	word_gen_pkg::word_in_t words [$];

	word_gen #(
		.RANGES_MAX(RANGES_MAX),
		.CHARS_MAX(CHARS_MAX)
	) UUT (
		.WORD_GEN_CLK(WORD_GEN_CLK), .rst_n(rst_n),
		.conf_data(conf_data), .conf_valid(conf_valid), .conf_ready(conf_ready),
		.word_in(word_in), .word_valid(word_valid), .word_ready(word_ready),
		.range_pos(range_pos),
		.cand(cand), .cand_valid(cand_valid), .cand_ready(cand_ready),
		.err_conf(err_conf)
	);

	word_gen_checker #(
		.RANGES_MAX(RANGES_MAX),
		.CHARS_MAX(CHARS_MAX)
	) u_checker (
		.WORD_GEN_CLK(WORD_GEN_CLK), .rst_n(rst_n),
		.cand(cand), .cand_valid(cand_valid), .cand_ready(cand_ready),
		.conf_ready(conf_ready), .word_ready(word_ready), .err_conf(err_conf),
		.range_pos(range_pos)
	);

	initial begin
		WORD_GEN_CLK = 1'b0;
		forever #20 WORD_GEN_CLK = ~WORD_GEN_CLK;
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge WORD_GEN_CLK);
		$display("timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
		$display("Simulation failed");
		$finish;
	end

	// ******************************
	// random source
	// ******************************

	// taps 32 22 2 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic rand_byte(output word_gen_pkg::char_t b);
		for (int i = 0; i < 8; i++) begin
			lfsr = lfsr_step(lfsr);
			b = {b[6:0], lfsr[0]};
		end
	endtask

	// random consumer stalls, else always ready
	always @(posedge WORD_GEN_CLK) begin
		if (stall_on) begin
			lfsr = lfsr_step(lfsr);
			cand_ready <= lfsr[0];
		end else begin
			cand_ready <= 1'b1;
		end
	end

	// ******************************
	// stimulus tasks
	// ******************************

	task automatic apply_reset();
		rst_n <= 1'b0;
		conf_valid <= 1'b0;
		word_valid <= 1'b0;
		repeat (4) @(posedge WORD_GEN_CLK);
		rst_n <= 1'b1;
	endtask

	task automatic send_byte(input word_gen_pkg::char_t b);
		conf_data <= b;
		conf_valid <= 1'b1;
		@(posedge WORD_GEN_CLK);
		while (!conf_ready) @(posedge WORD_GEN_CLK);
	endtask

	// range r char i is 'A' + 16*r + i
	task automatic load_conf(input int nr, input int n0, input int n1, input int n2);
		int n [3];
		word_gen_pkg::char_t c;
		n[0] = n0;
		n[1] = n1;
		n[2] = n2;
		u_checker.set_ranges(nr);
		send_byte(8'(nr));
		for (int r = 0; r < nr; r++) begin
			u_checker.set_range(r, n[r]);
			send_byte(8'(n[r]));
			for (int i = 0; i < n[r]; i++) begin
				c = 8'h41 + 8'(16 * r + i);
				u_checker.set_char(r, i, c);
				send_byte(c);
			end
		end
		send_byte(word_gen_pkg::CONF_MAGIC);
		conf_valid <= 1'b0;
	endtask

	// first n bytes of the packed list, lowest byte first
	task automatic send_bad(input int n, input logic [31:0] bytes);
		for (int i = 0; i < n; i++) begin
			send_byte(bytes[8*i +: 8]);
		end
		conf_valid <= 1'b0;
		// error state shows one edge after the offending byte
		@(posedge WORD_GEN_CLK);
	endtask

	// n random templates and a list end dummy
	task automatic build_words(input int n);
		word_gen_pkg::word_in_t w;
		words.delete();
		for (int i = 0; i <= n; i++) begin
			for (int c = 0; c < word_gen_pkg::WORD_MAX_LEN; c++) begin
				rand_byte(w.text[c]);
			end
			w.word_id = next_id;
			w.list_end = (i == n);
			next_id++;
			words.push_back(w);
			u_checker.add_template(w);
		end
	endtask

	task automatic send_words();
		foreach (words[i]) begin
			word_in <= words[i];
			word_valid <= 1'b1;
			@(posedge WORD_GEN_CLK);
			while (!word_ready) @(posedge WORD_GEN_CLK);
		end
		word_valid <= 1'b0;
	endtask

	// polled between edges, away from the checker updates
	task automatic wait_drained();
		@(negedge WORD_GEN_CLK);
		while (!u_checker.all_seen()) @(negedge WORD_GEN_CLK);
		// one more edge so the conf_ready check lands in this test
		@(negedge WORD_GEN_CLK);
		@(posedge WORD_GEN_CLK);
	endtask

	// ******************************
	// test sequence
	// ******************************

	initial begin
		conf_data <= '0;
		word_in <= '0;
		cand_ready <= 1'b1;
		stall_on <= 1'b0;
		// range 0 at char 1, range 1 at char 4, range 2 at char 6
		range_pos <= {3'd6, 3'd4, 3'd1};
		next_id = 16'h0100;
		apply_reset();

		// two ranges of 3 and 2 chars, 6 candidates per word
		u_checker.start_test();
		build_words(3);
		load_conf(2, 3, 2, 0);
		send_words();
		wait_drained();
		u_checker.end_test("two_ranges");

		// zero ranges, templates pass through
		u_checker.start_test();
		build_words(3);
		load_conf(0, 0, 0, 0);
		send_words();
		wait_drained();
		u_checker.end_test("zero_ranges");

		// new config after the list end of the previous one
		u_checker.start_test();
		build_words(2);
		load_conf(3, 2, 2, 3);
		send_words();
		wait_drained();
		u_checker.end_test("reconf_three_ranges");

		// random cand_ready stalls
		u_checker.start_test();
		build_words(3);
		stall_on <= 1'b1;
		load_conf(3, 4, 1, 3);
		send_words();
		wait_drained();
		stall_on <= 1'b0;
		u_checker.end_test("backpressure");

		// illegal configurations, each from reset
		apply_reset();
		u_checker.start_test();
		send_bad(1, 32'h0000_0004);
		u_checker.check_err_state();
		u_checker.end_test("bad_num_ranges");

		apply_reset();
		u_checker.start_test();
		send_bad(2, 32'h0000_0001);
		u_checker.check_err_state();
		u_checker.end_test("bad_num_chars");

		apply_reset();
		u_checker.start_test();
		send_bad(4, 32'hBA41_0101);
		u_checker.check_err_state();
		u_checker.end_test("bad_magic");

		u_checker.report_totals();
		if (u_checker.fail_cnt == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- word_gen.f
rtl/word_gen_pkg.sv
rtl/word_gen_char_range.sv
rtl/range_insert.sv
rtl/word_gen_conf.sv
rtl/word_gen_core.sv
rtl/word_gen.sv
dv/word_gen_checker.sv
dv/word_gen_tb.sv
